/* cpu_core.f */
+incdir+source
source/cpu_pkg.sv
source/imm_extend.sv
source/register_file.sv
source/instr_decode.sv
source/alu_execute.sv
source/result_select.sv
source/cpu_core.sv
tb/cpu_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cpu_core testbench with verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module cpu_core_tb -f cpu_core.f -o cpu_core_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/cpu_core_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF 'All tests passed!'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* tb/cpu_core_tb.sv */
`include "cpu_settings.svh"

module cpu_core_tb import cpu_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    typedef logic [`CPU_WORD_WIDTH-1:0] word_t;

    localparam int CLK_PERIOD = 40;
    localparam int EDGE_STEPS = 1600;  // 0.1 ns polls per clock wait.

    logic clk;
    logic rst_n;
    word_t instr;
    logic instr_valid;
    word_t mem_rdata;
    word_t pc;
    logic mem_read;
    logic mem_write;
    word_t mem_addr;
    word_t mem_wdata;
    logic wb_en;
    logic [1:0] wb_reg;
    word_t wb_data;
    logic illegal;

    int errors = 0;
    integer seed = 39198;
    word_t model_regs [`CPU_REG_COUNT];
    word_t model_pc;
    word_t model_mem [256];
    word_t mem [256];

    cpu_core dut_i (
        .clk(clk), .rst_n(rst_n), .instr(instr), .instr_valid(instr_valid),
        .mem_rdata(mem_rdata), .pc(pc), .mem_read(mem_read), .mem_write(mem_write),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .wb_en(wb_en), .wb_reg(wb_reg),
        .wb_data(wb_data), .illegal(illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // --------------------------------------------------
    // data memory, combinational read.
    // --------------------------------------------------
    assign mem_rdata = mem[mem_addr[7:0]];

    always @(posedge clk) begin
        if (mem_write) mem[mem_addr[7:0]] <= mem_wdata;
    end

    task automatic wait_fall();
        int steps;
        steps = 0;
        while (clk !== 1'b1 && steps < EDGE_STEPS) begin
            #0.1;
            steps++;
        end
        while (clk !== 1'b0 && steps < EDGE_STEPS) begin
            #0.1;
            steps++;
        end
        if (steps >= EDGE_STEPS) begin
            $display("Timeout: no falling clock edge within %0d polls", EDGE_STEPS);
            $display("Test failures found");
            $finish;
        end
    endtask

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic logic [1:0] pick_reg();
        logic [31:0] r;
        r = $random(seed);
        return r[1:0];
    endfunction

    function automatic logic [11:0] rand_target();
        logic [31:0] r;
        r = $random(seed);
        return r[11:0];
    endfunction

    function automatic word_t itype_word(logic [3:0] op, logic [1:0] rs, logic [1:0] rt,
                                         logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t rtype_word(logic [1:0] rs, logic [1:0] rt, logic [1:0] rd,
                                         logic [5:0] fn);
        return {4'd15, rs, rt, rd, fn};
    endfunction

    function automatic word_t jtype_word(logic [3:0] op, logic [11:0] target);
        return {op, target};
    endfunction

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic check_word(string what, word_t got, word_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg(string what, logic [1:0] got, logic [1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got r%0d, expected r%0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // one instruction: predict, drive, check outputs, commit, check pc.
    task automatic exec_instr(word_t word);
        word_t a, b, sx, seq, exp_data, exp_pc, exp_addr;
        logic [1:0] exp_reg;
        logic exp_wb, exp_rd, exp_wr, exp_ill;
        a = model_regs[word[11:10]];
        b = model_regs[word[9:8]];
        sx = {{8{word[7]}}, word[7:0]};
        seq = model_pc + 16'd1;
        exp_addr = a + sx;
        exp_pc = seq;
        exp_reg = word[9:8];
        exp_data = '0;
        exp_wb = 1'b0;
        exp_rd = 1'b0;
        exp_wr = 1'b0;
        exp_ill = 1'b0;
        case (opcode_e'(word[15:12]))
            OP_BNE: if (a != b) exp_pc = seq + sx;
            OP_BEQ: if (a == b) exp_pc = seq + sx;
            OP_BGZ: if (!a[15] && a != 16'd0) exp_pc = seq + sx;
            OP_BLZ: if (a[15]) exp_pc = seq + sx;
            OP_ADI: {exp_wb, exp_data} = {1'b1, a + sx};
            OP_ORI: {exp_wb, exp_data} = {1'b1, a | {8'h00, word[7:0]}};
            OP_LHI: {exp_wb, exp_data} = {1'b1, word[7:0], 8'h00};
            OP_LWD: {exp_wb, exp_rd, exp_data} = {2'b11, model_mem[exp_addr[7:0]]};
            OP_SWD: exp_wr = 1'b1;
            OP_JMP: exp_pc = {seq[15:12], word[11:0]};
            OP_JAL: begin
                exp_pc = {seq[15:12], word[11:0]};
                {exp_wb, exp_reg, exp_data} = {1'b1, 2'd2, seq};
            end
            OP_ALU: begin
                exp_wb = 1'b1;
                exp_reg = word[7:6];
                case (funct_e'(word[5:0]))
                    FN_ADD: exp_data = a + b;
                    FN_SUB: exp_data = a - b;
                    FN_AND: exp_data = a & b;
                    FN_ORR: exp_data = a | b;
                    FN_NOT: exp_data = ~a;
                    FN_TCP: exp_data = 16'd0 - a;
                    FN_SHL: exp_data = {a[14:0], 1'b0};
                    FN_SHR: exp_data = {a[15], a[15:1]};
                    FN_JPR: {exp_wb, exp_pc} = {1'b0, a};
                    FN_JRL: {exp_reg, exp_data, exp_pc} = {2'd2, seq, a};
                    default: {exp_wb, exp_ill} = 2'b01;
                endcase
            end
            default: exp_ill = 1'b1;
        endcase

        wait_fall();
        instr = word;
        instr_valid = 1'b1;
        #(CLK_PERIOD/4);
        check_flag("wb_en", wb_en, exp_wb);
        check_flag("illegal", illegal, exp_ill);
        check_flag("mem_read", mem_read, exp_rd);
        check_flag("mem_write", mem_write, exp_wr);
        if (exp_wb) begin
            check_reg("wb_reg", wb_reg, exp_reg);
            check_word("wb_data", wb_data, exp_data);
        end
        if (exp_rd || exp_wr) check_word("mem_addr", mem_addr, exp_addr);
        if (exp_wr) check_word("mem_wdata", mem_wdata, b);

        if (exp_wb) model_regs[exp_reg] = exp_data;
        if (exp_wr) model_mem[exp_addr[7:0]] = b;
        model_pc = exp_pc;
        wait_fall();
        instr_valid = 1'b0;
        check_word("pc", pc, model_pc);
    endtask

    task automatic load_regs();
        int r;
        for (r = 0; r < `CPU_REG_COUNT; r++) begin
            exec_instr(itype_word(OP_LHI, 2'd0, r[1:0], rand_byte()));
            exec_instr(itype_word(OP_ORI, r[1:0], r[1:0], rand_byte()));
        end
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic reset_and_immediates();
        check_word("pc after reset", pc, 16'd0);
        check_flag("mem_read after reset", mem_read, 1'b0);
        check_flag("mem_write after reset", mem_write, 1'b0);
        check_flag("wb_en after reset", wb_en, 1'b0);
        exec_instr(itype_word(OP_LHI, 2'd0, 2'd1, rand_byte()));
        exec_instr(itype_word(OP_ORI, 2'd1, 2'd1, rand_byte()));
        exec_instr(itype_word(OP_ORI, 2'd1, 2'd3, 8'hf3));  // zero-high with top bit set.
        exec_instr(itype_word(OP_ADI, 2'd1, 2'd2, rand_byte() | 8'h80));
        exec_instr(itype_word(OP_ADI, 2'd2, 2'd0, rand_byte()));
    endtask

    task automatic alu_functions();
        int f;
        load_regs();
        for (f = 0; f < 8; f++) begin
            exec_instr(rtype_word(pick_reg(), pick_reg(), pick_reg(), f[5:0]));
        end
    endtask

    task automatic loads_and_stores();
        logic [7:0] offset;
        load_regs();
        offset = rand_byte() & 8'h7f;
        exec_instr(itype_word(OP_SWD, 2'd1, 2'd2, offset));
        exec_instr(itype_word(OP_SWD, 2'd1, 2'd3, 8'hf0));  // negative offset.
        exec_instr(itype_word(OP_LWD, 2'd1, 2'd0, 8'hf0));
        exec_instr(itype_word(OP_LWD, 2'd1, 2'd3, offset));
    endtask

    task automatic branch_cases();
        exec_instr(itype_word(OP_LHI, 2'd0, 2'd0, 8'h33));
        exec_instr(itype_word(OP_LHI, 2'd0, 2'd1, 8'h33));
        exec_instr(itype_word(OP_LHI, 2'd0, 2'd2, 8'h12));  // positive.
        exec_instr(itype_word(OP_LHI, 2'd0, 2'd3, 8'h85));  // negative.
        exec_instr(itype_word(OP_BEQ, 2'd0, 2'd1, 8'd5));
        exec_instr(itype_word(OP_BEQ, 2'd0, 2'd2, 8'd5));
        exec_instr(itype_word(OP_BNE, 2'd0, 2'd2, 8'hfd));
        exec_instr(itype_word(OP_BNE, 2'd0, 2'd1, 8'hfd));
        exec_instr(itype_word(OP_BGZ, 2'd2, 2'd0, 8'd9));
        exec_instr(itype_word(OP_BGZ, 2'd3, 2'd0, 8'd9));
        exec_instr(itype_word(OP_BLZ, 2'd3, 2'd0, 8'hf8));
        exec_instr(itype_word(OP_BLZ, 2'd2, 2'd0, 8'hf8));
    endtask

    task automatic jumps_and_links();
        load_regs();
        exec_instr(itype_word(OP_LHI, 2'd0, 2'd1, rand_byte() | 8'h80));  // upper page.
        exec_instr(rtype_word(2'd1, 2'd0, 2'd0, FN_JPR));
        exec_instr(jtype_word(OP_JMP, rand_target()));
        exec_instr(jtype_word(OP_JAL, rand_target()));
        exec_instr(rtype_word(2'd3, 2'd0, 2'd0, FN_JRL));
    endtask

    task automatic illegal_and_idle();
        exec_instr(jtype_word(4'd12, 12'h5a5));
        exec_instr(rtype_word(2'd1, 2'd2, 2'd3, 6'd40));
        wait_fall();
        instr = itype_word(OP_SWD, 2'd1, 2'd2, 8'h04);  // store word, but not valid.
        instr_valid = 1'b0;
        #(CLK_PERIOD/4);
        check_flag("idle mem_write", mem_write, 1'b0);
        check_flag("idle mem_read", mem_read, 1'b0);
        check_flag("idle wb_en", wb_en, 1'b0);
        check_flag("idle illegal", illegal, 1'b0);
        wait_fall();
        check_word("idle pc", pc, model_pc);
    endtask

    initial begin
        int i;
        rst_n = 1'b0;
        instr = '0;
        instr_valid = 1'b0;
        for (i = 0; i < 256; i++) begin
            mem[i] = {i[7:0], ~i[7:0]};
            model_mem[i] = {i[7:0], ~i[7:0]};
        end
        for (i = 0; i < `CPU_REG_COUNT; i++) model_regs[i] = '0;
        model_pc = '0;
        wait_fall();
        wait_fall();
        rst_n = 1'b1;

        reset_and_immediates();
        alu_functions();
        loads_and_stores();
        branch_cases();
        jumps_and_links();
        illegal_and_idle();

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* source/cpu_core.sv */
`include "cpu_settings.svh"

module cpu_core import cpu_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`CPU_WORD_WIDTH-1:0]  instr,
    input  logic                        instr_valid,
    input  logic [`CPU_WORD_WIDTH-1:0]  mem_rdata,
    output logic [`CPU_WORD_WIDTH-1:0]  pc,
    output logic                        mem_read,
    output logic                        mem_write,
    output logic [`CPU_WORD_WIDTH-1:0]  mem_addr,
    output logic [`CPU_WORD_WIDTH-1:0]  mem_wdata,
    output logic                        wb_en,
    output logic [1:0]                  wb_reg,
    output logic [`CPU_WORD_WIDTH-1:0]  wb_data,
    output logic                        illegal
);

    // --------------------------------------------------
    // decode to execute wiring
    // --------------------------------------------------
    opcode_e                    opcode;
    funct_e                     funct;
    wb_src_e                    wb_src;
    logic [1:0]                 rs_addr;
    logic [1:0]                 rt_addr;
    logic [7:0]                 imm;
    logic [11:0]                target;
    logic                       use_imm;
    logic                       is_branch;
    logic                       is_jump;
    logic                       is_jump_reg;
    logic                       branch_taken;
    logic [`CPU_WORD_WIDTH-1:0] rs_data;
    logic [`CPU_WORD_WIDTH-1:0] ext_value;
    logic [`CPU_WORD_WIDTH-1:0] jump_target;
    logic [`CPU_WORD_WIDTH-1:0] pc_next_seq;

    instr_decode decode_i (
        .instr(instr), .instr_valid(instr_valid),
        .opcode(opcode), .funct(funct),
        .rs_addr(rs_addr), .rt_addr(rt_addr), .rd_addr(wb_reg),
        .imm(imm), .target(target),
        .reg_write(wb_en), .mem_read(mem_read), .mem_write(mem_write),
        .use_imm(use_imm), .is_branch(is_branch), .is_jump(is_jump),
        .is_jump_reg(is_jump_reg), .illegal(illegal), .wb_src(wb_src)
    );

    imm_extend extend_i (
        .opcode(opcode), .imm(imm), .target(target), .pc_next_seq(pc_next_seq),
        .ext_value(ext_value), .jump_target(jump_target)
    );

    // store data is the rt read port.
    register_file regs_i (
        .clk(clk), .rst_n(rst_n),
        .rs_addr(rs_addr), .rt_addr(rt_addr),
        .wr_en(wb_en), .wr_addr(wb_reg), .wr_data(wb_data),
        .rs_data(rs_data), .rt_data(mem_wdata)
    );

    alu_execute execute_i (
        .opcode(opcode), .funct(funct),
        .rs_data(rs_data), .rt_data(mem_wdata), .ext_value(ext_value), .use_imm(use_imm),
        .alu_result(mem_addr), .branch_taken(branch_taken)
    );

    result_select result_i (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .wb_src(wb_src),
        .alu_result(mem_addr), .mem_rdata(mem_rdata),
        .ext_value(ext_value), .jump_target(jump_target), .rs_data(rs_data),
        .branch_taken(branch_taken), .is_branch(is_branch),
        .is_jump(is_jump), .is_jump_reg(is_jump_reg),
        .pc(pc), .pc_next_seq(pc_next_seq), .wb_data(wb_data)
    );

endmodule

/* source/result_select.sv */
`include "cpu_settings.svh"

module result_select import cpu_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        instr_valid,
    input  wb_src_e                     wb_src,
    input  logic [`CPU_WORD_WIDTH-1:0]  alu_result,
    input  logic [`CPU_WORD_WIDTH-1:0]  mem_rdata,
    input  logic [`CPU_WORD_WIDTH-1:0]  ext_value,
    input  logic [`CPU_WORD_WIDTH-1:0]  jump_target,
    input  logic [`CPU_WORD_WIDTH-1:0]  rs_data,
    input  logic                        branch_taken,
    input  logic                        is_branch,
    input  logic                        is_jump,
    input  logic                        is_jump_reg,
    output logic [`CPU_WORD_WIDTH-1:0]  pc,
    output logic [`CPU_WORD_WIDTH-1:0]  pc_next_seq,
    output logic [`CPU_WORD_WIDTH-1:0]  wb_data
);

    logic [`CPU_WORD_WIDTH-1:0] branch_target;
    logic [`CPU_WORD_WIDTH-1:0] pc_next;

    assign pc_next_seq   = pc + `CPU_WORD_WIDTH'(1);
    assign branch_target = pc_next_seq + ext_value;

    always_comb begin
        case (wb_src)
            WB_MEM:  wb_data = mem_rdata;
            WB_LINK: wb_data = pc_next_seq;  // return address.
            default: wb_data = alu_result;
        endcase
    end

    // --------------------------------------------------
    // next pc, register jump wins.
    // --------------------------------------------------
    always_comb begin
        if (is_jump_reg) begin
            pc_next = rs_data;
        end else if (is_jump) begin
            pc_next = jump_target;
        end else if (is_branch && branch_taken) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc_next_seq;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `CPU_WORD_WIDTH'(`CPU_RESET_PC);
        end else if (instr_valid) begin
            pc <= pc_next;
        end
    end

endmodule

/* source/alu_execute.sv */
`include "cpu_settings.svh"

module alu_execute import cpu_pkg::*; (
    input  opcode_e                     opcode,
    input  funct_e                      funct,
    input  logic [`CPU_WORD_WIDTH-1:0]  rs_data,
    input  logic [`CPU_WORD_WIDTH-1:0]  rt_data,
    input  logic [`CPU_WORD_WIDTH-1:0]  ext_value,
    input  logic                        use_imm,
    output logic [`CPU_WORD_WIDTH-1:0]  alu_result,
    output logic                        branch_taken
);

    logic [`CPU_WORD_WIDTH-1:0] op_a;
    logic [`CPU_WORD_WIDTH-1:0] op_b;

    assign op_a = rs_data;
    assign op_b = use_imm ? ext_value : rt_data;

    // --------------------------------------------------
    // arithmetic and logic
    // --------------------------------------------------
    always_comb begin
        alu_result = '0;
        case (opcode)
            OP_ADI, OP_LWD, OP_SWD: alu_result = op_a + op_b;  // also the memory address.
            OP_ORI: alu_result = op_a | op_b;
            OP_LHI: alu_result = op_b;
            OP_ALU: begin
                case (funct)
                    FN_ADD:  alu_result = op_a + op_b;
                    FN_SUB:  alu_result = op_a - op_b;
                    FN_AND:  alu_result = op_a & op_b;
                    FN_ORR:  alu_result = op_a | op_b;
                    FN_NOT:  alu_result = ~op_a;
                    FN_TCP:  alu_result = ~op_a + `CPU_WORD_WIDTH'(1);
                    FN_SHL:  alu_result = op_a << 1;
                    FN_SHR:  alu_result = $signed(op_a) >>> 1;  // keeps the sign bit.
                    default: alu_result = '0;
                endcase
            end
            default: alu_result = '0;
        endcase
    end

    // --------------------------------------------------
    // branch conditions
    // --------------------------------------------------
    always_comb begin
        case (opcode)
            OP_BNE:  branch_taken = (rs_data != rt_data);
            OP_BEQ:  branch_taken = (rs_data == rt_data);
            OP_BGZ:  branch_taken = ($signed(rs_data) > 0);
            OP_BLZ:  branch_taken = ($signed(rs_data) < 0);
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

/* source/instr_decode.sv */
`include "cpu_settings.svh"

module instr_decode import cpu_pkg::*; (
    input  logic [`CPU_WORD_WIDTH-1:0]  instr,
    input  logic                        instr_valid,
    output opcode_e                     opcode,
    output funct_e                      funct,
    output logic [1:0]                  rs_addr,
    output logic [1:0]                  rt_addr,
    output logic [1:0]                  rd_addr,
    output logic [7:0]                  imm,
    output logic [11:0]                 target,
    output logic                        reg_write,
    output logic                        mem_read,
    output logic                        mem_write,
    output logic                        use_imm,
    output logic                        is_branch,
    output logic                        is_jump,
    output logic                        is_jump_reg,
    output logic                        illegal,
    output wb_src_e                     wb_src
);

    logic dec_reg_write;
    logic dec_mem_read;
    logic dec_mem_write;
    logic dec_use_imm;
    logic dec_branch;
    logic dec_jump;
    logic dec_jump_reg;
    logic dec_legal;

    // --------------------------------------------------
    // field split
    // --------------------------------------------------
    assign opcode  = opcode_e'(instr[15:12]);
    assign funct   = funct_e'(instr[5:0]);
    assign rs_addr = instr[11:10];
    assign rt_addr = instr[9:8];
    assign imm     = instr[7:0];
    assign target  = instr[11:0];

    always_comb begin
        dec_reg_write = 1'b0;
        dec_mem_read  = 1'b0;
        dec_mem_write = 1'b0;
        dec_use_imm   = 1'b0;
        dec_branch    = 1'b0;
        dec_jump      = 1'b0;
        dec_jump_reg  = 1'b0;
        dec_legal     = 1'b1;
        wb_src        = WB_ALU;
        rd_addr       = instr[9:8];  // rt by default.
        case (opcode)
            OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ: dec_branch = 1'b1;
            OP_ADI, OP_ORI, OP_LHI: begin
                dec_reg_write = 1'b1;
                dec_use_imm   = 1'b1;
            end
            OP_LWD: begin
                dec_reg_write = 1'b1;
                dec_use_imm   = 1'b1;
                dec_mem_read  = 1'b1;
                wb_src        = WB_MEM;
            end
            OP_SWD: begin
                dec_use_imm   = 1'b1;
                dec_mem_write = 1'b1;
            end
            OP_JMP: dec_jump = 1'b1;
            OP_JAL: begin
                dec_jump      = 1'b1;
                dec_reg_write = 1'b1;
                wb_src        = WB_LINK;
                rd_addr       = 2'd2;  // link register.
            end
            OP_ALU: begin
                case (funct)
                    FN_ADD, FN_SUB, FN_AND, FN_ORR,
                    FN_NOT, FN_TCP, FN_SHL, FN_SHR: begin
                        dec_reg_write = 1'b1;
                        rd_addr       = instr[7:6];
                    end
                    FN_JPR: dec_jump_reg = 1'b1;
                    FN_JRL: begin
                        dec_jump_reg  = 1'b1;
                        dec_reg_write = 1'b1;
                        wb_src        = WB_LINK;
                        rd_addr       = 2'd2;
                    end
                    default: dec_legal = 1'b0;
                endcase
            end
            default: dec_legal = 1'b0;
        endcase
    end

    // nothing leaves the decoder while idle.
    assign reg_write   = instr_valid & dec_reg_write;
    assign mem_read    = instr_valid & dec_mem_read;
    assign mem_write   = instr_valid & dec_mem_write;
    assign use_imm     = instr_valid & dec_use_imm;
    assign is_branch   = instr_valid & dec_branch;
    assign is_jump     = instr_valid & dec_jump;
    assign is_jump_reg = instr_valid & dec_jump_reg;
    assign illegal     = instr_valid & ~dec_legal;

endmodule

/* source/register_file.sv */
`include "cpu_settings.svh"

module register_file (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [1:0]                  rs_addr,
    input  logic [1:0]                  rt_addr,
    input  logic                        wr_en,
    input  logic [1:0]                  wr_addr,
    input  logic [`CPU_WORD_WIDTH-1:0]  wr_data,
    output logic [`CPU_WORD_WIDTH-1:0]  rs_data,
    output logic [`CPU_WORD_WIDTH-1:0]  rt_data
);

    logic [`CPU_WORD_WIDTH-1:0] regs [`CPU_REG_COUNT];

    // --------------------------------------------------
    // write port
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // --------------------------------------------------
    // read ports, no bypass.
    // --------------------------------------------------
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

endmodule

/* source/imm_extend.sv */
`include "cpu_settings.svh"

module imm_extend import cpu_pkg::*; (
    input  opcode_e                     opcode,
    input  logic [7:0]                  imm,
    input  logic [11:0]                 target,
    input  logic [`CPU_WORD_WIDTH-1:0]  pc_next_seq,
    output logic [`CPU_WORD_WIDTH-1:0]  ext_value,
    output logic [`CPU_WORD_WIDTH-1:0]  jump_target
);

    ext_kind_e ext_kind;

    always_comb begin
        case (opcode)
            OP_ADI, OP_LWD, OP_SWD,
            OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ: ext_kind = EXT_SIGN;
            OP_ORI:  ext_kind = EXT_ZERO_HIGH;
            OP_LHI:  ext_kind = EXT_ZERO_LOW;
            default: ext_kind = EXT_NONE;
        endcase
    end

    always_comb begin
        case (ext_kind)
            EXT_SIGN:      ext_value = {{(`CPU_WORD_WIDTH-8){imm[7]}}, imm};
            EXT_ZERO_HIGH: ext_value = {{(`CPU_WORD_WIDTH-8){1'b0}}, imm};
            EXT_ZERO_LOW:  ext_value = {imm, {(`CPU_WORD_WIDTH-8){1'b0}}};
            default:       ext_value = '0;
        endcase
    end

    // page bits come from the sequential pc.
    assign jump_target = {pc_next_seq[`CPU_WORD_WIDTH-1:12], target};

endmodule

/* source/cpu_pkg.sv */
package cpu_pkg;

    // --------------------------------------------------
    // instruction classes, from instr[15:12].
    // --------------------------------------------------
    typedef enum logic [3:0] {
        OP_BNE = 4'd0,
        OP_BEQ = 4'd1,
        OP_BGZ = 4'd2,
        OP_BLZ = 4'd3,
        OP_ADI = 4'd4,
        OP_ORI = 4'd5,
        OP_LHI = 4'd6,
        OP_LWD = 4'd7,
        OP_SWD = 4'd8,
        OP_JMP = 4'd9,
        OP_JAL = 4'd10,
        OP_ALU = 4'd15  // r-type, see funct.
    } opcode_e;

    // r-type function field, instr[5:0].
    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_NOT = 6'd4,
        FN_TCP = 6'd5,
        FN_SHL = 6'd6,
        FN_SHR = 6'd7,
        FN_JPR = 6'd25,
        FN_JRL = 6'd26
    } funct_e;

    // how the 8-bit immediate is widened.
    typedef enum logic [1:0] {
        EXT_SIGN,
        EXT_ZERO_HIGH,  // upper byte cleared.
        EXT_ZERO_LOW,   // imm lands in the upper byte.
        EXT_NONE
    } ext_kind_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_LINK
    } wb_src_e;

endpackage

/* source/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath and address width.
`define CPU_WORD_WIDTH 16

// number of general registers.
`define CPU_REG_COUNT 4

// pc value after reset.
`define CPU_RESET_PC 0

`endif
